/* src/router_pkg.sv */
`default_nettype none

package router_pkg;

  // crossbar size, one input and one output per port
  localparam int num_ports = 16;

  // header layout: destination bits, then a marker bit, then the pad
  localparam int addr_bits = 4;
  localparam int pad_cycles = 3;

  // holds a destination or the index of an owning input
  typedef logic [addr_bits-1:0] port_idx_t;

  // one bit per port
  typedef logic [num_ports-1:0] port_vec_t;

  // input slice FSM
  typedef enum logic [2:0] {
    st_idle,
    st_header,
    st_pad,
    st_request,
    st_connected
  } slice_state_t;

endpackage

`default_nettype wire

/* src/input_slice.sv */
`default_nettype none

module input_slice (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  frame_n,
  input  logic                  valid_n,
  input  logic                  din,
  input  logic                  grant,
  output logic                  busy_n,
  output logic                  req,
  output router_pkg::port_idx_t req_dest,
  output logic                  stage_frame_n,
  output logic                  stage_valid_n,
  output logic                  stage_din
);

  import router_pkg::*;

  slice_state_t state;
  logic         frame_d;
  logic [2:0]   cnt;
  port_idx_t    addr_sr;
  logic         connected;
  logic         frame_fall;

  assign connected  = (state == st_connected);
  assign frame_fall = frame_d & ~frame_n;

  // request is held from the end of the pad until the frame closes
  assign req      = (state == st_request) || connected;
  assign req_dest = addr_sr;

  // the source may only send data while connected
  assign busy_n = (state == st_idle) || connected;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state   <= st_idle;
      frame_d <= 1'b1;
      cnt     <= '0;
    end else begin
      frame_d <= frame_n;
      case (state)
        st_idle: begin
          // A0 rides on the cycle where frame_n falls
          if (frame_fall) begin
            cnt   <= 3'd1;
            state <= st_header;
          end
        end
        st_header: begin
          if (frame_n) begin
            state <= st_idle;
          end else if (cnt != 3'(addr_bits)) begin
            cnt <= cnt + 3'd1;
          end else if (din) begin
            cnt   <= '0;
            state <= st_pad;
          end else begin
            // no marker bit, drop the frame
            state <= st_idle;
          end
        end
        st_pad: begin
          if (frame_n) begin
            state <= st_idle;
          end else if (cnt == 3'(pad_cycles - 1)) begin
            state <= st_request;
          end else begin
            cnt <= cnt + 3'd1;
          end
        end
        st_request: begin
          if (frame_n) begin
            state <= st_idle;
          end else if (grant) begin
            state <= st_connected;
          end
        end
        st_connected: begin
          // frame_n goes high with the last data bit
          if (frame_n) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // address comes in lsb first, so shift towards bit 0
  always_ff @(posedge clock) begin
    if ((state == st_idle && frame_fall) ||
        (state == st_header && cnt != 3'(addr_bits))) begin
      addr_sr <= {din, addr_sr[addr_bits-1:1]};
    end
  end

  // stage register, first of the two cycles through the router
  always_ff @(posedge clock) begin
    if (!reset) begin
      stage_frame_n <= 1'b1;
      stage_valid_n <= 1'b1;
    end else begin
      stage_frame_n <= frame_n | ~connected;
      stage_valid_n <= valid_n | ~connected;
    end
  end

  always_ff @(posedge clock) begin
    stage_din <= din;
  end

endmodule

`default_nettype wire

/* src/arbiter_ring.sv */
`default_nettype none

module arbiter_ring (
  input  logic                  clock,
  input  logic                  reset,
  input  router_pkg::port_vec_t req,
  input  router_pkg::port_idx_t req_dest [router_pkg::num_ports],
  output router_pkg::port_vec_t grant,
  output router_pkg::port_idx_t owner [router_pkg::num_ports],
  output router_pkg::port_vec_t owned
);

  import router_pkg::*;

  port_idx_t head;
  port_idx_t head_next;
  port_vec_t grant_next;
  port_vec_t owned_next;
  port_idx_t owner_next [num_ports];

  always_comb begin
    logic      found;
    port_idx_t idx;

    found      = 1'b0;
    idx        = '0;
    head_next  = head;
    grant_next = grant;
    owned_next = owned;
    owner_next = owner;

    for (int o = 0; o < num_ports; o++) begin
      if (owned[o]) begin
        // owner dropped its request, so the frame is over
        if (!req[owner[o]]) begin
          owned_next[o]            = 1'b0;
          grant_next[owner[o]]     = 1'b0;
        end
      end else begin
        found = 1'b0;
        // scan from the head, wrapping through the 4-bit index
        for (int k = 0; k < num_ports; k++) begin
          idx = head + port_idx_t'(k);
          if (!found && req[idx] && req_dest[idx] == port_idx_t'(o)) begin
            found          = 1'b1;
            owned_next[o]  = 1'b1;
            owner_next[o]  = idx;
            grant_next[idx] = 1'b1;
            head_next      = idx + port_idx_t'(1);
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      head  <= '0;
      grant <= '0;
      owned <= '0;
    end else begin
      head  <= head_next;
      grant <= grant_next;
      owned <= owned_next;
    end
  end

  // registered owner index of each output
  always_ff @(posedge clock) begin
    owner <= owner_next;
  end

endmodule

`default_nettype wire

/* src/output_mux.sv */
`default_nettype none

module output_mux (
  input  logic                  clock,
  input  logic                  reset,
  input  router_pkg::port_idx_t owner [router_pkg::num_ports],
  input  router_pkg::port_vec_t owned,
  input  router_pkg::port_vec_t stage_frame_n,
  input  router_pkg::port_vec_t stage_valid_n,
  input  router_pkg::port_vec_t stage_din,
  output router_pkg::port_vec_t frameo_n,
  output router_pkg::port_vec_t valido_n,
  output router_pkg::port_vec_t dout
);

  import router_pkg::*;

  port_vec_t frame_sel;
  port_vec_t valid_sel;
  port_vec_t data_sel;

  // an output without an owner reads idle: frame and valid high, data 0
  always_comb begin
    for (int o = 0; o < num_ports; o++) begin
      if (owned[o]) begin
        frame_sel[o] = stage_frame_n[owner[o]];
        valid_sel[o] = stage_valid_n[owner[o]];
        data_sel[o]  = stage_din[owner[o]];
      end else begin
        frame_sel[o] = 1'b1;
        valid_sel[o] = 1'b1;
        data_sel[o]  = 1'b0;
      end
    end
  end

  // second pipeline cycle
  always_ff @(posedge clock) begin
    if (!reset) begin
      frameo_n <= '1;
      valido_n <= '1;
      dout     <= '0;
    end else begin
      frameo_n <= frame_sel;
      valido_n <= valid_sel;
      dout     <= data_sel;
    end
  end

endmodule

`default_nettype wire

/* src/router_top.sv */
`default_nettype none

module router_top (
  input  logic                  clock,
  input  logic                  reset,
  input  router_pkg::port_vec_t frame_n,
  input  router_pkg::port_vec_t valid_n,
  input  router_pkg::port_vec_t din,
  output router_pkg::port_vec_t busy_n,
  output router_pkg::port_vec_t frameo_n,
  output router_pkg::port_vec_t valido_n,
  output router_pkg::port_vec_t dout
);

  import router_pkg::*;

  port_vec_t req;
  port_vec_t grant;
  port_vec_t owned;
  port_idx_t req_dest [num_ports];
  port_idx_t owner [num_ports];
  port_vec_t stage_frame_n;
  port_vec_t stage_valid_n;
  port_vec_t stage_din;

  // one slice per input port
  for (genvar i = 0; i < num_ports; i++) begin : g_slice
    input_slice u_slice (
      .clock         (clock),
      .reset         (reset),
      .frame_n       (frame_n[i]),
      .valid_n       (valid_n[i]),
      .din           (din[i]),
      .grant         (grant[i]),
      .busy_n        (busy_n[i]),
      .req           (req[i]),
      .req_dest      (req_dest[i]),
      .stage_frame_n (stage_frame_n[i]),
      .stage_valid_n (stage_valid_n[i]),
      .stage_din     (stage_din[i])
    );
  end

  arbiter_ring u_arbiter (
    .clock    (clock),
    .reset    (reset),
    .req      (req),
    .req_dest (req_dest),
    .grant    (grant),
    .owner    (owner),
    .owned    (owned)
  );

  output_mux u_output_mux (
    .clock         (clock),
    .reset         (reset),
    .owner         (owner),
    .owned         (owned),
    .stage_frame_n (stage_frame_n),
    .stage_valid_n (stage_valid_n),
    .stage_din     (stage_din),
    .frameo_n      (frameo_n),
    .valido_n      (valido_n),
    .dout          (dout)
  );

endmodule

`default_nettype wire

/* dv/router_checker.sv */
`default_nettype none

module router_checker (
  input logic                  clock,
  input logic                  reset,
  input router_pkg::port_vec_t frame_n,
  input router_pkg::port_vec_t busy_n,
  input router_pkg::port_vec_t req,
  input router_pkg::port_vec_t grant,
  input router_pkg::port_idx_t req_dest [router_pkg::num_ports],
  input router_pkg::port_idx_t owner [router_pkg::num_ports],
  input router_pkg::port_vec_t owned,
  input router_pkg::port_vec_t valido_n
);

  import router_pkg::*;

  logic [4:0] claims [num_ports];

  // how many granted inputs point at each output
  always_comb begin
    for (int o = 0; o < num_ports; o++) begin
      claims[o] = '0;
      for (int i = 0; i < num_ports; i++) begin
        if (grant[i] && req_dest[i] == port_idx_t'(o)) begin
          claims[o] = claims[o] + 5'd1;
        end
      end
    end
  end

  for (genvar i = 0; i < num_ports; i++) begin : g_port
    // an owner still held off by busy_n shows no valid bit two cycles on
    a_no_valid_while_busy: assert property (@(posedge clock) disable iff (!reset)
      $past(owned[i] && !busy_n[owner[i]], 2) |-> valido_n[i])
      else $error("output %0d showed valid data from a held-off input", i);

    a_single_owner: assert property (@(posedge clock) disable iff (!reset)
      claims[i] <= 5'd1)
      else $error("output %0d is granted to more than one input", i);

    // busy_n high with req still up only happens while connected
    a_busy_held: assert property (@(posedge clock) disable iff (!reset)
      (busy_n[i] && req[i] && !frame_n[i]) |=> busy_n[i])
      else $error("input %0d lost busy_n in the middle of its frame", i);
  end

endmodule

`default_nettype wire

/* dv/router_tb.sv */
`default_nettype none

module router_tb;

  import router_pkg::*;

  localparam int max_pkts = 32;
  localparam int fields = 8;
  localparam int header_cycles = addr_bits + 1 + pad_cycles;
  localparam int num_tests = 5;

  logic        clock;
  logic        reset;
  port_vec_t   frame_n;
  port_vec_t   valid_n;
  port_vec_t   din;
  port_vec_t   busy_n;
  port_vec_t   frameo_n;
  port_vec_t   valido_n;
  port_vec_t   dout;

  logic [31:0] vec_mem [0:fields*max_pkts-1];
  int          pk_test [max_pkts];
  int          pk_src [max_pkts];
  int          pk_dst [max_pkts];
  int          pk_start [max_pkts];
  int          pk_len [max_pkts];
  logic [31:0] pk_data [max_pkts];
  logic [31:0] pk_gap [max_pkts];
  int          first_data [max_pkts];
  int          rise_cycle [max_pkts];
  int          exp_q [num_ports][$];
  logic        in_frame [num_ports];
  logic [31:0] got_bits [num_ports];
  int          got_len [num_ports];
  int          fall_cycle [num_ports];
  int          num_pkts;
  int          cycle;
  int          errors;
  int          failed_tests;
  int          received;
  int          pending;
  int          limit;

  router_top uut (
    .clock    (clock),
    .reset    (reset),
    .frame_n  (frame_n),
    .valid_n  (valid_n),
    .din      (din),
    .busy_n   (busy_n),
    .frameo_n (frameo_n),
    .valido_n (valido_n),
    .dout     (dout)
  );

  bind router_top router_checker u_checker (
    .clock    (clock),
    .reset    (reset),
    .frame_n  (frame_n),
    .busy_n   (busy_n),
    .req      (req),
    .grant    (grant),
    .req_dest (req_dest),
    .owner    (owner),
    .owned    (owned),
    .valido_n (valido_n)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  function automatic string test_name(input int t);
    case (t)
      1: return "reset values";
      2: return "single packet";
      3: return "parallel distinct outputs";
      4: return "valid gaps";
      default: return "output contention";
    endcase
  endfunction

  // data cycles with a gap bit carry nothing, the rest pack down in order
  function automatic int valid_count(input int p);
    int n;
    n = 0;
    for (int i = 0; i < pk_len[p]; i++) begin
      if (!pk_gap[p][i]) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic logic [31:0] valid_bits(input int p);
    logic [31:0] v;
    int          n;
    v = '0;
    n = 0;
    for (int i = 0; i < pk_len[p]; i++) begin
      if (!pk_gap[p][i]) begin
        v[n] = pk_data[p][i];
        n++;
      end
    end
    return v;
  endfunction

  task automatic load_vectors();
    int base;
    int total;
    total = 0;
    for (int i = 0; i < fields * max_pkts; i++) begin
      vec_mem[i] = '1;
    end
    $readmemh("dv/packet_vectors.txt", vec_mem);
    num_pkts = 0;
    while (num_pkts < max_pkts && vec_mem[fields*num_pkts] != 32'hffffffff) begin
      base = fields * num_pkts;
      pk_test[num_pkts] = int'(vec_mem[base]);
      pk_src[num_pkts] = int'(vec_mem[base+1]);
      pk_dst[num_pkts] = int'(vec_mem[base+2]);
      pk_start[num_pkts] = int'(vec_mem[base+3]);
      pk_len[num_pkts] = int'(vec_mem[base+4]);
      if (vec_mem[base+5] != 32'h0) begin
        pk_data[num_pkts] = $urandom;
      end else begin
        pk_data[num_pkts] = vec_mem[base+6];
      end
      pk_gap[num_pkts] = vec_mem[base+7];
      total = total + pk_len[num_pkts] + header_cycles;
      num_pkts++;
    end
    limit = total * 4 + 1000;
  endtask

  // header, marker and pad, then hold until the slice is connected
  task automatic send_packet(input int p);
    int s;
    s = pk_src[p];
    repeat (pk_start[p]) @(negedge clock);
    for (int b = 0; b < header_cycles; b++) begin
      @(negedge clock);
      frame_n[s] = 1'b0;
      if (b < addr_bits) begin
        din[s] = pk_dst[p][b];
      end else begin
        din[s] = (b == addr_bits);
      end
    end
    @(negedge clock);
    din[s] = 1'b0;
    while (!busy_n[s]) begin
      @(negedge clock);
    end
    first_data[p] = cycle;
    for (int i = 0; i < pk_len[p]; i++) begin
      if (i > 0) begin
        @(negedge clock);
      end
      din[s] = pk_data[p][i];
      valid_n[s] = pk_gap[p][i];
      frame_n[s] = (i == pk_len[p] - 1);
    end
    @(negedge clock);
    valid_n[s] = 1'b1;
    din[s] = 1'b0;
    pending--;
  endtask

  task automatic check_frame(input int o);
    int p;
    received++;
    if (exp_q[o].size() == 0) begin
      $display("error %0t: output %0d delivered a frame nobody sent to it", $time, o);
      errors++;
    end else begin
      p = exp_q[o].pop_front();
      rise_cycle[p] = cycle;
      if (got_len[o] != valid_count(p)) begin
        $display("error %0t: output %0d got %0d bits, expected %0d", $time, o,
                 got_len[o], valid_count(p));
        errors++;
      end else if (got_bits[o] != valid_bits(p)) begin
        $display("error %0t: output %0d data %h, expected %h", $time, o,
                 got_bits[o], valid_bits(p));
        errors++;
      end
      if (fall_cycle[o] != first_data[p] + 2) begin
        $display("error %0t: output %0d frame fell at cycle %0d, expected %0d", $time, o,
                 fall_cycle[o], first_data[p] + 2);
        errors++;
      end
    end
  endtask

  // collect valid bits between the fall of frameo_n and the cycle it rises
  always @(negedge clock) begin
    if (reset) begin
      for (int o = 0; o < num_ports; o++) begin
        if (!in_frame[o]) begin
          if (!frameo_n[o]) begin
            in_frame[o] = 1'b1;
            got_len[o] = 0;
            got_bits[o] = '0;
            fall_cycle[o] = cycle;
          end else if (!valido_n[o]) begin
            $display("error %0t: output %0d valid outside a frame", $time, o);
            errors++;
          end
        end
        if (in_frame[o]) begin
          if (!valido_n[o]) begin
            if (got_len[o] < 32) begin
              got_bits[o][got_len[o]] = dout[o];
            end
            got_len[o]++;
          end
          if (frameo_n[o]) begin
            in_frame[o] = 1'b0;
            check_frame(o);
          end
        end
      end
    end
  end

  task automatic report_test(input int t, input int start_errs);
    if (errors == start_errs) begin
      $display("test %0d %s: ok", t, test_name(t));
    end else begin
      $display("test %0d %s: %0d errors", t, test_name(t), errors - start_errs);
      failed_tests++;
    end
  endtask

  task automatic run_test(input int t);
    int start_errs;
    int expected;
    start_errs = errors;
    expected = 0;
    received = 0;
    for (int p = 0; p < num_pkts; p++) begin
      if (pk_test[p] == t) begin
        exp_q[pk_dst[p]].push_back(p);
        expected++;
        pending++;
      end
    end
    for (int p = 0; p < num_pkts; p++) begin
      if (pk_test[p] == t) begin
        fork
          automatic int q = p;
          send_packet(q);
        join_none
      end
    end
    while (pending > 0 || received < expected) begin
      @(negedge clock);
    end
    repeat (8) @(negedge clock);
    // a later frame to a shared output waits for the earlier one to close
    for (int p = 0; p < num_pkts; p++) begin
      for (int q = p + 1; q < num_pkts; q++) begin
        if (pk_test[p] == t && pk_test[q] == t && pk_dst[p] == pk_dst[q] &&
            first_data[q] <= rise_cycle[p]) begin
          $display("error %0t: input %0d busy_n high at cycle %0d, frame closed at %0d",
                   $time, pk_src[q], first_data[q], rise_cycle[p]);
          errors++;
        end
      end
    end
    for (int o = 0; o < num_ports; o++) begin
      if (exp_q[o].size() != 0) begin
        $display("error %0t: output %0d is missing %0d frames", $time, o, exp_q[o].size());
        errors++;
        exp_q[o].delete();
      end
    end
    report_test(t, start_errs);
  endtask

  initial begin
    int start_errs;
    frame_n = '1;
    valid_n = '1;
    din = '0;
    reset = 1'b0;
    errors = 0;
    failed_tests = 0;
    pending = 0;
    for (int o = 0; o < num_ports; o++) begin
      in_frame[o] = 1'b0;
    end
    void'($urandom(32'he6906460));
    load_vectors();
    repeat (10) @(negedge clock);
    reset = 1'b1;
    @(negedge clock);
    start_errs = errors;
    if (busy_n !== '1 || frameo_n !== '1 || valido_n !== '1 || dout !== '0) begin
      $display("error %0t: busy_n %h frameo_n %h valido_n %h dout %h after reset",
               $time, busy_n, frameo_n, valido_n, dout);
      errors++;
    end
    report_test(1, start_errs);
    for (int t = 2; t <= num_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests run, %0d failed, %0d errors", num_tests, failed_tests, errors);
    if (errors == 0 && failed_tests == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // limit comes from the packet lengths once the vectors are loaded
  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge clock);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/packet_vectors.txt */
// columns in hex: test src dst start len rnd data gap
// rnd 1 draws the data from $urandom, a set gap bit sends that cycle with valid_n high
2 3 9 0 0c 0 00000a5b 00000000
3 0 5 0 10 0 0000c3e1 00000000
3 1 c 0 14 1 00000000 00000000
3 7 2 1 0a 0 0000026d 00000000
3 e 0 3 18 1 00000000 00000000
4 5 5 0 14 0 000c3a96 00004924
4 a f 2 20 1 00000000 30f00c06
5 2 7 0 12 0 0002b3c9 00000000
5 9 7 3 0e 0 00001e5d 00000110
5 b 4 0 0a 1 00000000 00000000
5 4 4 1 0f 0 00005a3c 00000022
// end of list
ffffffff

/* flist.f */
src/router_pkg.sv
src/input_slice.sv
src/arbiter_ring.sv
src/output_mux.sv
src/router_top.sv
dv/router_checker.sv
dv/router_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --timing --assert
TOP      := router_tb
FLIST    := flist.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
